// File: src.f
design/AvPkg.sv
design/VideoTimingIf.sv
design/PixelIf.sv
design/VideoFormatTiming.sv
design/ColorBarPattern.sv
design/TmdsEncoder.sv
design/DviEncoder.sv
design/AvTestPatterns.sv
sim/AvTestPatternsTb.sv

// File: Makefile
# Verilator build and run of the DVI test pattern testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module AvTestPatternsTb -Mdir obj_dir
	./obj_dir/VAvTestPatternsTb | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/AvTestPatternsTb.sv
//******************************
// Testbench for the DVI source that decodes the three TMDS channels
// and checks sync, raster counts, pixels and DC balance
//******************************

`timescale 1ns/10ps

module AvTestPatternsTb;

    // Raster under test matches the small format of the DUT defaults
    localparam int H_ACTIVE      = 64;
    localparam int H_FRONT_PORCH = 4;
    localparam int H_SYNC_PULSE  = 8;
    localparam int H_BACK_PORCH  = 8;
    localparam int V_ACTIVE      = 16;
    localparam int V_FRONT_PORCH = 2;
    localparam int V_SYNC_PULSE  = 2;
    localparam int V_BACK_PORCH  = 3;

    localparam int H_TOTAL         = H_ACTIVE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int V_TOTAL         = V_ACTIVE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;
    localparam int FRAME_TOTAL     = H_TOTAL * V_TOTAL;
    localparam int RESET_CYCLES    = 10;
    localparam int FRAMES_TO_CHECK = 2;
    // Two watched frames follow at most one partial frame after reset
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 3 * FRAME_TOTAL;

    // One expected pixel with rgb packed as {red, green, blue}
    typedef struct packed {
        int          vPos;
        int          hPos;
        logic [23:0] rgb;
    } PixelEntry;

    localparam int TABLE_SIZE = 14;

    // Bars are 8 pixels wide over rows 0 to 11 and ramp rows 12 to 15 hold hPos times 4
    localparam PixelEntry PIXEL_TABLE [TABLE_SIZE] = '{
        '{0,  0,  AvPkg::BAR_COLORS[0]},
        '{1,  9,  AvPkg::BAR_COLORS[1]},
        '{2,  23, AvPkg::BAR_COLORS[2]},
        '{4,  24, AvPkg::BAR_COLORS[3]},
        '{6,  39, AvPkg::BAR_COLORS[4]},
        '{8,  44, AvPkg::BAR_COLORS[5]},
        '{11, 50, AvPkg::BAR_COLORS[6]},
        '{0,  63, AvPkg::BAR_COLORS[7]},
        '{11, 63, AvPkg::BAR_COLORS[7]},
        '{12, 0,  24'h000000},
        '{12, 1,  24'h040404},
        '{14, 10, 24'h282828},
        '{13, 32, 24'h808080},
        '{15, 63, 24'hFCFCFC}
    };

    logic       pixelClock = 1'b0;
    logic       arstN;
    logic [9:0] dviChannel0;
    logic [9:0] dviChannel1;
    logic [9:0] dviChannel2;

    // Monitor state is derived from the channel words themselves
    logic        released      = 1'b0;
    logic        seenActivity  = 1'b0;
    logic        tracking      = 1'b0;
    logic        prevData      = 1'b0;
    logic        prevVSync     = 1'b0;
    int          cycleCount    = 0;
    int          framesChecked = 0;
    int          hSyncRun      = 0;
    int          vSyncRun      = 0;
    int          lineCount     = 0;
    int          pixelCount    = 0;
    int          lineStartCycle = 0;
    int          lineBalance [3];
    logic [23:0] capturedFrame [V_ACTIVE][H_ACTIVE];

    AvTestPatterns #(
        .H_ACTIVE      (H_ACTIVE),
        .H_FRONT_PORCH (H_FRONT_PORCH),
        .H_SYNC_PULSE  (H_SYNC_PULSE),
        .H_BACK_PORCH  (H_BACK_PORCH),
        .V_ACTIVE      (V_ACTIVE),
        .V_FRONT_PORCH (V_FRONT_PORCH),
        .V_SYNC_PULSE  (V_SYNC_PULSE),
        .V_BACK_PORCH  (V_BACK_PORCH)
    ) dut (
        .pixelClock  (pixelClock),
        .arstN       (arstN),
        .dviChannel0 (dviChannel0),
        .dviChannel1 (dviChannel1),
        .dviChannel2 (dviChannel2)
    );

    always #5 pixelClock = ~pixelClock;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Error: %s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped on a stream error");
    endtask

    // Returns the index of the control pair {C1, C0} in a word or -1 for anything else
    function automatic int controlIndex(input logic [9:0] word);
        if (word === AvPkg::CTRL_CODE_00) return 0;
        if (word === AvPkg::CTRL_CODE_01) return 1;
        if (word === AvPkg::CTRL_CODE_10) return 2;
        if (word === AvPkg::CTRL_CODE_11) return 3;
        return -1;
    endfunction

    // Undoes the TMDS data coding and sets bit 8 of the result for a legal word
    function automatic logic [8:0] decodeWord(input logic [9:0] word);
        logic [7:0] q;
        logic [7:0] d;
        logic       xnorChain;
        int         ones;
        // Bit 9 flags an inverted byte
        q = word[9] ? ~word[7:0] : word[7:0];
        d[0] = q[0];
        // Bit 8 high means the encoder chained with XOR
        for (int i = 1; i < 8; i++) begin
            d[i] = word[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        // The encoder must have picked the chain that its own rule gives for this byte
        ones = $countones(d);
        xnorChain = (ones > 4) || ((ones == 4) && !d[0]);
        return {(xnorChain == !word[8]), d};
    endfunction

    // Compares the captured frame against every table entry with one channel per colour
    task automatic comparePixels();
        int          v;
        int          h;
        logic [23:0] got;
        logic [23:0] want;
        for (int i = 0; i < TABLE_SIZE; i++) begin
            v = PIXEL_TABLE[i].vPos;
            h = PIXEL_TABLE[i].hPos;
            got = capturedFrame[v][h];
            want = PIXEL_TABLE[i].rgb;
            check($sformatf("dviChannel2 red at (%0d,%0d)", v, h),
                  32'(got[23:16]), 32'(want[23:16]));
            check($sformatf("dviChannel1 green at (%0d,%0d)", v, h),
                  32'(got[15:8]), 32'(want[15:8]));
            check($sformatf("dviChannel0 blue at (%0d,%0d)", v, h),
                  32'(got[7:0]), 32'(want[7:0]));
        end
    endtask

    // A vSync falling edge closes the previous frame and opens a new one
    task automatic startFrame();
        check("dviChannel0 vSync words", vSyncRun, V_SYNC_PULSE * H_TOTAL);
        if (tracking) begin
            check("dviChannel0 data lines per frame", lineCount, V_ACTIVE);
            comparePixels();
            framesChecked++;
        end
        tracking = 1'b1;
        lineCount = 0;
    endtask

    // Called on every falling edge once reset is released
    task automatic monitorWords();
        logic [9:0] words [3];
        int         ctrl [3];
        logic [8:0] decoded [3];
        logic       isData;
        logic       hs;
        logic       vs;
        words[0] = dviChannel0;
        words[1] = dviChannel1;
        words[2] = dviChannel2;
        for (int c = 0; c < 3; c++) begin
            ctrl[c] = controlIndex(words[c]);
        end
        isData = (ctrl[0] < 0);

        // Channel 0 stays on the idle code from reset until the first data word
        if (!seenActivity) begin
            if (isData) begin
                seenActivity = 1'b1;
            end else begin
                check("dviChannel0", 32'(words[0]), 32'(AvPkg::CTRL_CODE_00));
            end
        end

        // All three channels switch between data and blanking together
        for (int c = 1; c < 3; c++) begin
            if ((ctrl[c] < 0) != isData) begin
                abortRun($sformatf("dviChannel%0d is out of step with dviChannel0", c));
            end
        end

        if (!isData) begin
            // Only channel 0 carries sync while the colour channels idle
            check("dviChannel1", 32'(words[1]), 32'(AvPkg::CTRL_CODE_00));
            check("dviChannel2", 32'(words[2]), 32'(AvPkg::CTRL_CODE_00));
            hs = (ctrl[0] == 1) || (ctrl[0] == 3);
            vs = (ctrl[0] >= 2);
        end else begin
            hs = 1'b0;
            vs = 1'b0;
            for (int c = 0; c < 3; c++) begin
                decoded[c] = decodeWord(words[c]);
                if (!decoded[c][8]) begin
                    abortRun($sformatf("dviChannel%0d sent 0x%03h, neither a control code %s",
                                       c, words[c], "nor a valid TMDS data word"));
                end
            end
            // First data word of a line
            if (!prevData) begin
                if (tracking && (lineCount > 0)) begin
                    check("dviChannel0 line spacing", cycleCount - lineStartCycle, H_TOTAL);
                end
                lineStartCycle = cycleCount;
                pixelCount = 0;
                for (int c = 0; c < 3; c++) begin
                    lineBalance[c] = 0;
                end
            end
            // Ones minus zeros of the whole 10-bit word are summed along the line
            for (int c = 0; c < 3; c++) begin
                lineBalance[c] += 2 * $countones(words[c]) - 10;
                if ((lineBalance[c] > 10) || (lineBalance[c] < -10)) begin
                    abortRun($sformatf("running disparity of dviChannel%0d reached %0d",
                                       c, lineBalance[c]));
                end
            end
            if (tracking && (lineCount < V_ACTIVE) && (pixelCount < H_ACTIVE)) begin
                capturedFrame[lineCount][pixelCount] =
                    {decoded[2][7:0], decoded[1][7:0], decoded[0][7:0]};
            end
            pixelCount++;
        end

        // Each hSync pulse must be exactly one sync window long
        if (hs) begin
            // The sync window opens after the active pixels and the front porch
            if (hSyncRun == 0) begin
                check("dviChannel0 hSync start", (cycleCount - lineStartCycle) % H_TOTAL,
                      H_ACTIVE + H_FRONT_PORCH);
            end
            hSyncRun++;
        end else if (hSyncRun > 0) begin
            check("dviChannel0 hSync words", hSyncRun, H_SYNC_PULSE);
            hSyncRun = 0;
        end

        if (vs && !prevVSync) begin
            // vSync opens at a line start once the front porch lines have passed
            check("dviChannel0 vSync start", cycleCount - lineStartCycle,
                  (V_FRONT_PORCH + 1) * H_TOTAL);
            vSyncRun = 0;
        end
        if (vs) begin
            vSyncRun++;
        end
        if (!vs && prevVSync) begin
            startFrame();
        end

        // End of a run of data words closes the line
        if (prevData && !isData) begin
            check("dviChannel0 data words per line", pixelCount, H_ACTIVE);
            if (tracking) begin
                lineCount++;
            end
        end
        prevData = isData;
        prevVSync = vs;
    endtask

    always @(negedge pixelClock) begin
        if (released) begin
            monitorWords();
        end
    end

    // Stops a run that never completes its frames
    always @(posedge pixelClock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: two full frames were not seen in %0d cycles", cycleCount);
            $display("*** FAILED ***");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(negedge pixelClock);
        arstN = 1'b1;
        released = 1'b1;
        wait (framesChecked == FRAMES_TO_CHECK);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: design/AvTestPatterns.sv
//******************************
// DVI colour bar source, raster size set by the parameters below
//******************************

`timescale 1ns/10ps

module AvTestPatterns #(
    parameter int H_ACTIVE      = 64,
    parameter int H_FRONT_PORCH = 4,
    parameter int H_SYNC_PULSE  = 8,
    parameter int H_BACK_PORCH  = 8,
    parameter int V_ACTIVE      = 16,
    parameter int V_FRONT_PORCH = 2,
    parameter int V_SYNC_PULSE  = 2,
    parameter int V_BACK_PORCH  = 3
) (
    input  logic       pixelClock,
    input  logic       arstN,
    output logic [9:0] dviChannel0,
    output logic [9:0] dviChannel1,
    output logic [9:0] dviChannel2
);

    // Raster state from the timing generator
    VideoTimingIf timingBus ();

    // Coloured pixels for the encoder
    PixelIf pixelBus ();

    VideoFormatTiming #(
        .H_ACTIVE      (H_ACTIVE),
        .H_FRONT_PORCH (H_FRONT_PORCH),
        .H_SYNC_PULSE  (H_SYNC_PULSE),
        .H_BACK_PORCH  (H_BACK_PORCH),
        .V_ACTIVE      (V_ACTIVE),
        .V_FRONT_PORCH (V_FRONT_PORCH),
        .V_SYNC_PULSE  (V_SYNC_PULSE),
        .V_BACK_PORCH  (V_BACK_PORCH)
    ) rasterTiming (
        .pixelClock (pixelClock),
        .arstN      (arstN),
        .timing     (timingBus.source)
    );

    // The pattern only needs the active size to place bars and ramp
    ColorBarPattern #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) colorBars (
        .pixelClock (pixelClock),
        .arstN      (arstN),
        .timing     (timingBus.sink),
        .pixel      (pixelBus.source)
    );

    DviEncoder dvi (
        .pixelClock (pixelClock),
        .arstN      (arstN),
        .pixel      (pixelBus.sink),
        .channel0   (dviChannel0),
        .channel1   (dviChannel1),
        .channel2   (dviChannel2)
    );

endmodule

// File: design/DviEncoder.sv
//******************************
// DVI data channels built from three TMDS encoders
//******************************

`timescale 1ns/10ps

module DviEncoder (
    input  logic       pixelClock,
    input  logic       arstN,
    PixelIf.sink       pixel,
    output logic [9:0] channel0,
    output logic [9:0] channel1,
    output logic [9:0] channel2
);

    // Channel 0 carries blue and the two sync bits as its control pair
    TmdsEncoder blueEncoder (
        .pixelClock (pixelClock),
        .arstN      (arstN),
        .dataEnable (pixel.dataEnable),
        .control    ({pixel.vSync, pixel.hSync}),
        .data       (pixel.blue),
        .symbol     (channel0)
    );

    // Green and red have no control information in DVI
    TmdsEncoder greenEncoder (
        .pixelClock (pixelClock),
        .arstN      (arstN),
        .dataEnable (pixel.dataEnable),
        .control    (2'b00),
        .data       (pixel.green),
        .symbol     (channel1)
    );

    TmdsEncoder redEncoder (
        .pixelClock (pixelClock),
        .arstN      (arstN),
        .dataEnable (pixel.dataEnable),
        .control    (2'b00),
        .data       (pixel.red),
        .symbol     (channel2)
    );

endmodule

// File: design/TmdsEncoder.sv
//******************************
// Two-stage TMDS 8b/10b encoder for one DVI channel
//******************************

`timescale 1ns/10ps

module TmdsEncoder (
    input  logic       pixelClock,
    input  logic       arstN,
    input  logic       dataEnable,
    input  logic [1:0] control,
    input  logic [7:0] data,
    output logic [9:0] symbol
);

    logic [3:0]        dataOnes;
    logic              useXnor;
    logic [8:0]        qmNext;
    logic [8:0]        qm;
    logic              enableStage;
    logic [1:0]        controlStage;
    logic [3:0]        qmOnes;
    logic signed [5:0] balance;
    logic signed [5:0] disparity;
    logic signed [5:0] nextDisparity;
    logic [9:0]        dataWord;
    logic [9:0]        controlWord;

    // Stage one builds the transition-minimized word
    // XNOR is picked when it gives fewer transitions for this byte
    always_comb begin
        dataOnes = 4'($countones(data));
        useXnor  = (dataOnes > 4'd4) || ((dataOnes == 4'd4) && !data[0]);
        qmNext[0] = data[0];
        for (int i = 1; i < 8; i++) begin
            qmNext[i] = useXnor ? ~(qmNext[i-1] ^ data[i]) : (qmNext[i-1] ^ data[i]);
        end
        // Bit 8 tells the receiver which chain was used, 1 for XOR
        qmNext[8] = !useXnor;
    end

    always_ff @(posedge pixelClock or negedge arstN) begin
        if (!arstN) begin
            enableStage  <= 1'b0;
            controlStage <= 2'b00;
        end else begin
            enableStage  <= dataEnable;
            controlStage <= control;
        end
    end

    always_ff @(posedge pixelClock) begin
        qm <= qmNext;
    end

    // Stage two keeps the line DC balanced
    // balance is ones minus zeros of the low byte of qm
    always_comb begin
        qmOnes  = 4'($countones(qm[7:0]));
        balance = $signed({1'b0, qmOnes, 1'b0}) - 6'sd8;
        if ((disparity == 6'sd0) || (balance == 6'sd0)) begin
            // No bias either way so bit 8 alone decides the inversion
            dataWord = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            nextDisparity = qm[8] ? disparity + balance : disparity - balance;
        end else if ((!disparity[5] && !balance[5]) || (disparity[5] && balance[5])) begin
            // The word would push the running count further from zero, so invert it
            dataWord = {1'b1, qm[8], ~qm[7:0]};
            nextDisparity = disparity - balance + (qm[8] ? 6'sd2 : 6'sd0);
        end else begin
            dataWord = {1'b0, qm[8], qm[7:0]};
            nextDisparity = disparity + balance - (qm[8] ? 6'sd0 : 6'sd2);
        end
    end

    always_comb begin
        case (controlStage)
            2'b00:   controlWord = AvPkg::CTRL_CODE_00;
            2'b01:   controlWord = AvPkg::CTRL_CODE_01;
            2'b10:   controlWord = AvPkg::CTRL_CODE_10;
            default: controlWord = AvPkg::CTRL_CODE_11;
        endcase
    end

    // Blanking sends a control word and restarts the disparity count
    always_ff @(posedge pixelClock or negedge arstN) begin
        if (!arstN) begin
            symbol    <= AvPkg::CTRL_CODE_00;
            disparity <= 6'sd0;
        end else if (!enableStage) begin
            symbol    <= controlWord;
            disparity <= 6'sd0;
        end else begin
            symbol    <= dataWord;
            disparity <= nextDisparity;
        end
    end

endmodule

// File: design/ColorBarPattern.sv
//******************************
// Colour bars over the upper rows with a grey ramp below, one clock of latency
//******************************

`timescale 1ns/10ps

module ColorBarPattern #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 16
) (
    input  logic       pixelClock,
    input  logic       arstN,
    VideoTimingIf.sink timing,
    PixelIf.source     pixel
);

    localparam int HW = AvPkg::H_POS_WIDTH;
    localparam int VW = AvPkg::V_POS_WIDTH;
    localparam int IW = $clog2(AvPkg::BAR_COUNT);

    // Pixels per bar, H_ACTIVE is expected to divide evenly
    localparam logic [HW-1:0] BAR_LAST = HW'(H_ACTIVE / AvPkg::BAR_COUNT - 1);

    // Rows above this line show bars, the rest show the ramp
    localparam logic [VW-1:0] BAR_ROWS = VW'((V_ACTIVE * 3) / 4);

    logic [HW-1:0] barPixel;
    logic [IW-1:0] barIndex;
    logic [23:0]   rgb;
    logic [7:0]    rampLevel;

    // Position inside the current bar, which avoids a divide by the bar width
    // Blanking always separates lines, so clearing there restarts each line at bar 0
    always_ff @(posedge pixelClock or negedge arstN) begin
        if (!arstN) begin
            barPixel <= '0;
            barIndex <= '0;
        end else if (!timing.dataEnable) begin
            barPixel <= '0;
            barIndex <= '0;
        end else if (barPixel == BAR_LAST) begin
            barPixel <= '0;
            barIndex <= barIndex + 1'b1;
        end else begin
            barPixel <= barPixel + 1'b1;
        end
    end

    // The ramp is hPos times 4 kept to 8 bits
    assign rampLevel = {timing.hPos[5:0], 2'b00};

    always_comb begin
        if (!timing.dataEnable) begin
            rgb = 24'h000000;
        end else if (timing.vPos < BAR_ROWS) begin
            rgb = AvPkg::BAR_COLORS[barIndex];
        end else begin
            rgb = {rampLevel, rampLevel, rampLevel};
        end
    end

    // Sync and blanking take the same single register stage as the colour
    always_ff @(posedge pixelClock or negedge arstN) begin
        if (!arstN) begin
            pixel.dataEnable <= 1'b0;
            pixel.hSync      <= 1'b0;
            pixel.vSync      <= 1'b0;
        end else begin
            pixel.dataEnable <= timing.dataEnable;
            pixel.hSync      <= timing.hSync;
            pixel.vSync      <= timing.vSync;
        end
    end

    always_ff @(posedge pixelClock) begin
        pixel.red   <= rgb[23:16];
        pixel.green <= rgb[15:8];
        pixel.blue  <= rgb[7:0];
    end

endmodule

// File: design/VideoFormatTiming.sv
//******************************
// Progressive raster generator with registered sync, blanking and position
//******************************

`timescale 1ns/10ps

module VideoFormatTiming #(
    parameter int H_ACTIVE      = 64,
    parameter int H_FRONT_PORCH = 4,
    parameter int H_SYNC_PULSE  = 8,
    parameter int H_BACK_PORCH  = 8,
    parameter int V_ACTIVE      = 16,
    parameter int V_FRONT_PORCH = 2,
    parameter int V_SYNC_PULSE  = 2,
    parameter int V_BACK_PORCH  = 3
) (
    input  logic         pixelClock,
    input  logic         arstN,
    VideoTimingIf.source timing
);

    localparam int HW = AvPkg::H_POS_WIDTH;
    localparam int VW = AvPkg::V_POS_WIDTH;

    // Totals in pixels per line and lines per frame
    localparam int H_TOTAL = H_ACTIVE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;

    // Region boundaries in counter units
    // Each line runs active, front porch, sync, back porch and frames do the same in lines
    localparam logic [HW-1:0] H_LAST       = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_ACTIVE_END = HW'(H_ACTIVE);
    localparam logic [HW-1:0] H_SYNC_START = HW'(H_ACTIVE + H_FRONT_PORCH);
    localparam logic [HW-1:0] H_SYNC_END   = HW'(H_ACTIVE + H_FRONT_PORCH + H_SYNC_PULSE);
    localparam logic [VW-1:0] V_LAST       = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_ACTIVE_END = VW'(V_ACTIVE);
    localparam logic [VW-1:0] V_SYNC_START = VW'(V_ACTIVE + V_FRONT_PORCH);
    localparam logic [VW-1:0] V_SYNC_END   = VW'(V_ACTIVE + V_FRONT_PORCH + V_SYNC_PULSE);

    logic [HW-1:0] hCount;
    logic [VW-1:0] vCount;
    logic          lineEnd;
    logic          frameEnd;
    logic          inActive;
    logic          inHSync;
    logic          inVSync;

    assign lineEnd  = (hCount == H_LAST);
    assign frameEnd = (vCount == V_LAST);

    // The horizontal counter steps every clock and the vertical one once per line
    always_ff @(posedge pixelClock or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            vCount <= frameEnd ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Region decode of the current counter state
    always_comb begin
        inActive = (hCount < H_ACTIVE_END) && (vCount < V_ACTIVE_END);
        inHSync  = (hCount >= H_SYNC_START) && (hCount < H_SYNC_END);
        // vSync covers whole lines so it changes together with the line start
        inVSync  = (vCount >= V_SYNC_START) && (vCount < V_SYNC_END);
    end

    // All outputs are registered so they arrive one clock after the counter state
    always_ff @(posedge pixelClock or negedge arstN) begin
        if (!arstN) begin
            timing.dataEnable <= 1'b0;
            timing.hSync      <= 1'b0;
            timing.vSync      <= 1'b0;
            timing.hPos       <= '0;
            timing.vPos       <= '0;
        end else begin
            timing.dataEnable <= inActive;
            timing.hSync      <= inHSync;
            timing.vSync      <= inVSync;
            // Inside the active region the position is simply the counter value
            timing.hPos       <= hCount;
            timing.vPos       <= vCount;
        end
    end

endmodule

// File: design/PixelIf.sv
//******************************
// Pixel bus from the pattern generator to the DVI encoder
//******************************

`timescale 1ns/10ps

interface PixelIf;

    // Sync and blanking, already aligned with the colour below
    logic dataEnable;
    logic hSync;
    logic vSync;

    // One 8-bit sample per colour component
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    // The pattern generator produces the pixel stream
    modport source (output dataEnable, hSync, vSync, red, green, blue);

    // The DVI encoder consumes it, one pixel per clock
    modport sink (input dataEnable, hSync, vSync, red, green, blue);

endinterface

// File: design/VideoTimingIf.sv
//******************************
// Raster timing bus from the timing generator to the pattern generator
//******************************

`timescale 1ns/10ps

interface VideoTimingIf;

    // High while the raster is inside the active picture
    logic dataEnable;

    // Active-high sync pulses
    logic hSync;
    logic vSync;

    // Active position, only meaningful while dataEnable is high
    logic [AvPkg::H_POS_WIDTH-1:0] hPos;
    logic [AvPkg::V_POS_WIDTH-1:0] vPos;

    // The timing generator drives everything
    modport source (output dataEnable, hSync, vSync, hPos, vPos);

    // The pattern generator only listens
    modport sink (input dataEnable, hSync, vSync, hPos, vPos);

endinterface

// File: design/AvPkg.sv
//******************************
// Shared widths, TMDS control words and bar colours
// for the DVI test pattern source
//******************************

package AvPkg;

    // Raster position widths, wide enough for 1080p totals
    localparam int H_POS_WIDTH = 12;
    localparam int V_POS_WIDTH = 11;

    // TMDS control words sent during blanking
    // The suffix is the control pair {C1, C0}, which is {vSync, hSync} on channel 0
    localparam logic [9:0] CTRL_CODE_00 = 10'b1101010100;
    localparam logic [9:0] CTRL_CODE_01 = 10'b0010101011;
    localparam logic [9:0] CTRL_CODE_10 = 10'b0101010100;
    localparam logic [9:0] CTRL_CODE_11 = 10'b1010101011;

    // Number of vertical bars across the active width
    localparam int BAR_COUNT = 8;

    // Bar colours from left to right, packed as {red, green, blue}
    // This is the usual full-saturation bar order
    localparam logic [23:0] BAR_COLORS [BAR_COUNT] = '{
        24'hFFFFFF,
        24'hFFFF00,
        24'h00FFFF,
        24'h00FF00,
        24'hFF00FF,
        24'hFF0000,
        24'h0000FF,
        24'h000000
    };

endpackage
